// ==== logic/noc_bridge_defs.svh ====
`ifndef NOC_BRIDGE_DEFS_SVH
`define NOC_BRIDGE_DEFS_SVH

`define NOC_AXI_DATA_W 32
`define NOC_ADDR_W 16
`define NOC_ID_W 4
`define NOC_FLIT_W 40

// mesh dimensions and coordinate width
`define NOC_MESH_X 4
`define NOC_MESH_Y 4
`define NOC_COORD_W 2
`define NOC_CNT_W 8

// low bit of each routing header field
`define NOC_HDR_DST_Y_LSB 0
`define NOC_HDR_DST_X_LSB 2
`define NOC_HDR_SRC_Y_LSB 4
`define NOC_HDR_SRC_X_LSB 6
`define NOC_HDR_CNT_LSB 8

// AW/AR subheader fields
`define NOC_SUB_BURST_LSB 0
`define NOC_SUB_SIZE_LSB 2
`define NOC_SUB_LEN_LSB 5
`define NOC_SUB_ADDR_LSB 13
`define NOC_SUB_ID_LSB 29

`endif

// ==== logic/noc_flit_pkg.sv ====
`include "noc_bridge_defs.svh"

package noc_flit_pkg;

    // one flit on the mesh stream
    typedef logic [`NOC_FLIT_W-1:0] flit_t;

    typedef logic [`NOC_COORD_W-1:0] coord_x_t;
    typedef logic [`NOC_COORD_W-1:0] coord_y_t;

    // number of flits that follow the routing header
    typedef logic [`NOC_CNT_W-1:0] pkt_count_t;

    // carried on the stream id lines so the far end can tell flits apart
    typedef enum logic [1:0] {
        FLIT_HEAD = 2'd0,
        FLIT_AW   = 2'd1,
        FLIT_AR   = 2'd2,
        FLIT_W    = 2'd3
    } flit_kind_e;

endpackage

// ==== logic/noc_axi_pkg.sv ====
`include "noc_bridge_defs.svh"

package noc_axi_pkg;

    typedef logic [`NOC_ID_W-1:0] axi_id_t;
    typedef logic [`NOC_ADDR_W-1:0] axi_addr_t;
    typedef logic [7:0] axi_len_t;
    typedef logic [2:0] axi_size_t;
    typedef logic [1:0] axi_burst_t;
    typedef logic [`NOC_AXI_DATA_W-1:0] axi_data_t;
    typedef logic [`NOC_AXI_DATA_W/8-1:0] axi_strb_t;

    // which request channel owns the current packet
    typedef enum logic {
        REQ_WRITE = 1'b0,
        REQ_READ  = 1'b1
    } req_kind_e;

endpackage

// ==== logic/burst_if.sv ====
`timescale 1ns/100ps

interface burst_if;

    logic                  load; // pulses when the AW flit is accepted so len is taken
    noc_axi_pkg::axi_len_t len;
    logic                  beat; // one W flit accepted
    logic                  last;

    modport fsm (
        output load, len, beat,
        input  last
    );

    modport counter (
        input  load, len, beat,
        output last
    );

endinterface

// ==== logic/req_arbiter.sv ====
`timescale 1ns/100ps

module req_arbiter (
    input  logic                   ACLK,
    input  logic                   ARESETn,
    input  logic                   awvalid_i,
    input  logic                   arvalid_i,
    input  logic                   pkt_done_i,
    output logic                   grant_valid_o,
    output noc_axi_pkg::req_kind_e grant_kind_o
);
    import noc_axi_pkg::*;

    logic      lock_q;
    req_kind_e kind_q;
    req_kind_e prio_q;
    req_kind_e pick;

    always_comb begin
        if (awvalid_i && arvalid_i) begin
            pick = prio_q;
        end else if (awvalid_i) begin
            pick = REQ_WRITE;
        end else begin
            pick = REQ_READ;
        end
    end

    // the kind is frozen from the first offered header until the packet ends
    assign grant_valid_o = lock_q | awvalid_i | arvalid_i;
    assign grant_kind_o  = lock_q ? kind_q : pick;

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            lock_q <= 1'b0;
            kind_q <= REQ_WRITE;
            prio_q <= REQ_WRITE;
        end else if (pkt_done_i) begin
            lock_q <= 1'b0;
            if (kind_q == REQ_WRITE) begin // the other side goes first next time
                prio_q <= REQ_READ;
            end else begin
                prio_q <= REQ_WRITE;
            end
        end else if (!lock_q && grant_valid_o) begin
            lock_q <= 1'b1;
            kind_q <= pick;
        end
    end

    // the FSM can only finish a packet that it was granted
    a_done_needs_grant: assert property (
        @(posedge ACLK) disable iff (!ARESETn) pkt_done_i |-> lock_q
    );

endmodule

// ==== logic/packet_fsm.sv ====
`timescale 1ns/100ps

module packet_fsm (
    input  logic                      ACLK,
    input  logic                      ARESETn,
    input  logic                      grant_valid_i,
    input  noc_axi_pkg::req_kind_e    grant_kind_i,
    input  noc_axi_pkg::axi_len_t     awlen_i,
    input  logic                      wvalid_i,
    input  logic                      m_tready_i,
    output logic                      awready_o,
    output logic                      arready_o,
    output logic                      wready_o,
    output logic                      m_tvalid_o,
    output logic                      m_tlast_o,
    output logic                      pkt_done_o,
    output noc_flit_pkg::flit_kind_e  flit_kind_o,
    burst_if.fsm                      burst
);
    import noc_axi_pkg::*;
    import noc_flit_pkg::*;

    typedef enum logic [1:0] {
        IDLE_HEAD,
        SEND_AW,
        SEND_W,
        SEND_AR
    } state_e;

    state_e state_q;
    state_e state_d;

    assign burst.len = awlen_i;

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            state_q <= IDLE_HEAD;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d     = state_q;
        awready_o   = 1'b0;
        arready_o   = 1'b0;
        wready_o    = 1'b0;
        m_tvalid_o  = 1'b0;
        m_tlast_o   = 1'b0;
        pkt_done_o  = 1'b0;
        flit_kind_o = FLIT_HEAD;
        burst.load  = 1'b0;
        burst.beat  = 1'b0;
        case (state_q)
            IDLE_HEAD: begin
                m_tvalid_o = grant_valid_i; // header needs nothing but the grant
                if (grant_valid_i && m_tready_i) begin
                    if (grant_kind_i == REQ_WRITE) begin
                        state_d = SEND_AW;
                    end else begin
                        state_d = SEND_AR;
                    end
                end
            end
            SEND_AW: begin
                // awvalid is still high here since the grant came from it
                flit_kind_o = FLIT_AW;
                m_tvalid_o  = 1'b1;
                awready_o   = m_tready_i;
                burst.load  = m_tready_i;
                if (m_tready_i) begin
                    state_d = SEND_W;
                end
            end
            SEND_W: begin
                flit_kind_o = FLIT_W;
                m_tvalid_o  = wvalid_i;
                wready_o    = m_tready_i;
                m_tlast_o   = wvalid_i & burst.last;
                if (wvalid_i && m_tready_i) begin
                    burst.beat = 1'b1;
                    if (burst.last) begin
                        pkt_done_o = 1'b1;
                        state_d    = IDLE_HEAD;
                    end
                end
            end
            SEND_AR: begin
                flit_kind_o = FLIT_AR;
                m_tvalid_o  = 1'b1;
                m_tlast_o   = 1'b1;
                arready_o   = m_tready_i;
                if (m_tready_i) begin
                    pkt_done_o = 1'b1;
                    state_d    = IDLE_HEAD;
                end
            end
            default: begin
                state_d = IDLE_HEAD;
            end
        endcase
    end

    a_one_ready: assert property (
        @(posedge ACLK) disable iff (!ARESETn) $onehot0({awready_o, arready_o, wready_o})
    );

endmodule

// ==== logic/beat_counter.sv ====
`timescale 1ns/100ps

module beat_counter (
    input  logic       ACLK,
    input  logic       ARESETn,
    input  logic       wlast_i,
    burst_if.counter   burst
);
    import noc_axi_pkg::*;

    axi_len_t count_q; // beats still to come after the current one

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            count_q <= '0;
        end else if (burst.load) begin
            count_q <= burst.len;
        end else if (burst.beat) begin
            count_q <= count_q - axi_len_t'(1);
        end
    end

    assign burst.last = (count_q == '0);

    // master's WLAST has to agree with AWLEN
    a_wlast_match: assert property (
        @(posedge ACLK) disable iff (!ARESETn) burst.beat |-> (wlast_i == burst.last)
    );

endmodule

// ==== logic/flit_packer.sv ====
`timescale 1ns/100ps
`include "noc_bridge_defs.svh"

module flit_packer #(
    parameter int ROUTER_X = 0,
    parameter int ROUTER_Y = 0
) (
    input  noc_flit_pkg::flit_kind_e flit_kind_i,
    input  noc_axi_pkg::req_kind_e   grant_kind_i,
    input  noc_axi_pkg::axi_id_t     awid_i,
    input  noc_axi_pkg::axi_addr_t   awaddr_i,
    input  noc_axi_pkg::axi_len_t    awlen_i,
    input  noc_axi_pkg::axi_size_t   awsize_i,
    input  noc_axi_pkg::axi_burst_t  awburst_i,
    input  noc_axi_pkg::axi_id_t     arid_i,
    input  noc_axi_pkg::axi_addr_t   araddr_i,
    input  noc_axi_pkg::axi_len_t    arlen_i,
    input  noc_axi_pkg::axi_size_t   arsize_i,
    input  noc_axi_pkg::axi_burst_t  arburst_i,
    input  noc_axi_pkg::axi_data_t   wdata_i,
    input  noc_axi_pkg::axi_strb_t   wstrb_i,
    output noc_flit_pkg::flit_t      tdata_o,
    output noc_flit_pkg::flit_kind_e tid_o,
    output noc_axi_pkg::axi_strb_t   tstrb_o
);
    import noc_axi_pkg::*;
    import noc_flit_pkg::*;

    function automatic flit_t pack_sub(axi_id_t id, axi_addr_t addr, axi_len_t len,
                                       axi_size_t size, axi_burst_t burst);
        flit_t f;
        f = '0;
        f[`NOC_SUB_BURST_LSB +: $bits(axi_burst_t)] = burst;
        f[`NOC_SUB_SIZE_LSB +: $bits(axi_size_t)]   = size;
        f[`NOC_SUB_LEN_LSB +: $bits(axi_len_t)]     = len;
        f[`NOC_SUB_ADDR_LSB +: $bits(axi_addr_t)]   = addr;
        f[`NOC_SUB_ID_LSB +: $bits(axi_id_t)]       = id;
        return f;
    endfunction

    axi_id_t    dst_idx;
    pkt_count_t hdr_count;
    flit_t      head_flit;

    always_comb begin
        // id 1 sits at (0,0), and id 0 wraps around to the far corner
        if (grant_kind_i == REQ_WRITE) begin
            dst_idx   = awid_i - axi_id_t'(1);
            hdr_count = pkt_count_t'(awlen_i) + pkt_count_t'(2);
        end else begin
            dst_idx   = arid_i - axi_id_t'(1);
            hdr_count = pkt_count_t'(1);
        end
        head_flit = '0;
        head_flit[`NOC_HDR_DST_X_LSB +: `NOC_COORD_W] = coord_x_t'(dst_idx % `NOC_MESH_X);
        head_flit[`NOC_HDR_DST_Y_LSB +: `NOC_COORD_W] = coord_y_t'(dst_idx / `NOC_MESH_X);
        head_flit[`NOC_HDR_SRC_X_LSB +: `NOC_COORD_W] = coord_x_t'(ROUTER_X);
        head_flit[`NOC_HDR_SRC_Y_LSB +: `NOC_COORD_W] = coord_y_t'(ROUTER_Y);
        head_flit[`NOC_HDR_CNT_LSB +: `NOC_CNT_W]     = hdr_count;
    end

    always_comb begin
        tstrb_o = '1;
        case (flit_kind_i)
            FLIT_AW: tdata_o = pack_sub(awid_i, awaddr_i, awlen_i, awsize_i, awburst_i);
            FLIT_AR: tdata_o = pack_sub(arid_i, araddr_i, arlen_i, arsize_i, arburst_i);
            FLIT_W: begin
                tdata_o = flit_t'(wdata_i); // data sits in the low bits with the rest zero
                tstrb_o = wstrb_i;
            end
            default: tdata_o = head_flit;
        endcase
    end

    assign tid_o = flit_kind_i;

endmodule

// ==== logic/noc_req_bridge.sv ====
`timescale 1ns/100ps

module noc_req_bridge #(
    parameter int ROUTER_X = 0,
    parameter int ROUTER_Y = 0
) (
    input  logic                     ACLK,
    input  logic                     ARESETn,

    input  logic                     awvalid_i,
    output logic                     awready_o,
    input  noc_axi_pkg::axi_id_t     awid_i,
    input  noc_axi_pkg::axi_addr_t   awaddr_i,
    input  noc_axi_pkg::axi_len_t    awlen_i,
    input  noc_axi_pkg::axi_size_t   awsize_i,
    input  noc_axi_pkg::axi_burst_t  awburst_i,

    input  logic                     wvalid_i,
    output logic                     wready_o,
    input  noc_axi_pkg::axi_data_t   wdata_i,
    input  noc_axi_pkg::axi_strb_t   wstrb_i,
    input  logic                     wlast_i,

    input  logic                     arvalid_i,
    output logic                     arready_o,
    input  noc_axi_pkg::axi_id_t     arid_i,
    input  noc_axi_pkg::axi_addr_t   araddr_i,
    input  noc_axi_pkg::axi_len_t    arlen_i,
    input  noc_axi_pkg::axi_size_t   arsize_i,
    input  noc_axi_pkg::axi_burst_t  arburst_i,

    output logic                     m_tvalid_o,
    input  logic                     m_tready_i,
    output noc_flit_pkg::flit_t      m_tdata_o,
    output noc_flit_pkg::flit_kind_e m_tid_o,
    output noc_axi_pkg::axi_strb_t   m_tstrb_o,
    output logic                     m_tlast_o
);
    import noc_axi_pkg::*;
    import noc_flit_pkg::*;

    logic       grant_valid;
    req_kind_e  grant_kind;
    logic       pkt_done;
    flit_kind_e flit_kind;

    burst_if burst_i ();

    req_arbiter arbiter_i (
        .ACLK          (ACLK),
        .ARESETn       (ARESETn),
        .awvalid_i     (awvalid_i),
        .arvalid_i     (arvalid_i),
        .pkt_done_i    (pkt_done),
        .grant_valid_o (grant_valid),
        .grant_kind_o  (grant_kind)
    );

    packet_fsm fsm_i (
        .ACLK          (ACLK),
        .ARESETn       (ARESETn),
        .grant_valid_i (grant_valid),
        .grant_kind_i  (grant_kind),
        .awlen_i       (awlen_i),
        .wvalid_i      (wvalid_i),
        .m_tready_i    (m_tready_i),
        .awready_o     (awready_o),
        .arready_o     (arready_o),
        .wready_o      (wready_o),
        .m_tvalid_o    (m_tvalid_o),
        .m_tlast_o     (m_tlast_o),
        .pkt_done_o    (pkt_done),
        .flit_kind_o   (flit_kind),
        .burst         (burst_i.fsm)
    );

    beat_counter counter_i (
        .ACLK    (ACLK),
        .ARESETn (ARESETn),
        .wlast_i (wlast_i),
        .burst   (burst_i.counter)
    );

    flit_packer #(
        .ROUTER_X (ROUTER_X),
        .ROUTER_Y (ROUTER_Y)
    ) packer_i (
        .flit_kind_i  (flit_kind),
        .grant_kind_i (grant_kind),
        .awid_i       (awid_i),
        .awaddr_i     (awaddr_i),
        .awlen_i      (awlen_i),
        .awsize_i     (awsize_i),
        .awburst_i    (awburst_i),
        .arid_i       (arid_i),
        .araddr_i     (araddr_i),
        .arlen_i      (arlen_i),
        .arsize_i     (arsize_i),
        .arburst_i    (arburst_i),
        .wdata_i      (wdata_i),
        .wstrb_i      (wstrb_i),
        .tdata_o      (m_tdata_o),
        .tid_o        (m_tid_o),
        .tstrb_o      (m_tstrb_o)
    );

endmodule

// ==== testbench/tb_noc_req_bridge.sv ====
`timescale 1ns/100ps
`include "noc_bridge_defs.svh"

module tb_noc_req_bridge;
    import noc_axi_pkg::*;
    import noc_flit_pkg::*;

    localparam int ROUTER_X = 1;
    localparam int ROUTER_Y = 2;
    localparam int WAIT_LIMIT = 200;
    localparam logic [31:0] LFSR_SEED = 32'h29492f06;
    localparam int CH_AW = 0;
    localparam int CH_W = 1;
    localparam int CH_AR = 2;

    typedef struct packed {
        flit_t      data;
        logic [1:0] kind;
        axi_strb_t  strb;
        logic       last;
    } flit_rec_t;

    logic       ACLK;
    logic       ARESETn;
    logic       awvalid, awready, wvalid, wready, wlast, arvalid, arready;
    axi_id_t    awid, arid;
    axi_addr_t  awaddr, araddr;
    axi_len_t   awlen, arlen;
    axi_size_t  awsize, arsize;
    axi_burst_t awburst, arburst;
    axi_data_t  wdata;
    axi_strb_t  wstrb;
    logic       m_tvalid, m_tready, m_tlast;
    flit_t      m_tdata;
    flit_kind_e m_tid;
    axi_strb_t  m_tstrb;

    flit_rec_t   got_q[$];
    flit_rec_t   exp_q[$];
    axi_data_t   wdata_buf[0:15];
    axi_strb_t   wstrb_buf[0:15];
    logic [31:0] data_lfsr;
    logic [31:0] ready_lfsr;
    logic        bp_en; // random tready pattern on the stream sink
    int          ar_seen;

    noc_req_bridge #(.ROUTER_X(ROUTER_X), .ROUTER_Y(ROUTER_Y)) dut_i (
        .ACLK(ACLK), .ARESETn(ARESETn),
        .awvalid_i(awvalid), .awready_o(awready), .awid_i(awid), .awaddr_i(awaddr),
        .awlen_i(awlen), .awsize_i(awsize), .awburst_i(awburst),
        .wvalid_i(wvalid), .wready_o(wready), .wdata_i(wdata), .wstrb_i(wstrb),
        .wlast_i(wlast),
        .arvalid_i(arvalid), .arready_o(arready), .arid_i(arid), .araddr_i(araddr),
        .arlen_i(arlen), .arsize_i(arsize), .arburst_i(arburst),
        .m_tvalid_o(m_tvalid), .m_tready_i(m_tready), .m_tdata_o(m_tdata),
        .m_tid_o(m_tid), .m_tstrb_o(m_tstrb), .m_tlast_o(m_tlast)
    );

    always #5 ACLK = ~ACLK;

    always @(negedge ACLK) begin
        if (bp_en) begin
            m_tready <= ready_lfsr[0];
            ready_lfsr <= lfsr_next(ready_lfsr);
        end else begin
            m_tready <= 1'b1;
        end
    end

    // stream sink and per-cycle protocol checks
    always @(posedge ACLK) begin
        flit_rec_t r;
        if (ARESETn && m_tvalid && m_tready) begin
            r.data = m_tdata;
            r.kind = m_tid;
            r.strb = m_tstrb;
            r.last = m_tlast;
            got_q.push_back(r);
        end
        if (arready) ar_seen++;
        if (ARESETn && !m_tready) begin
            assert (!awready && !arready && !wready)
                else report_error("an AXI ready was high while m_tready_i was low");
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'hB4BCD35C;
        end
        return s >> 1;
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], data_lfsr[0]};
            data_lfsr = lfsr_next(data_lfsr);
        end
    endtask

    task automatic stop_with_failure();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic report_error(input string msg);
        $display("%s", msg);
        stop_with_failure();
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("mismatch %s: got %h expected %h", name, got, exp);
        stop_with_failure();
    endtask

    function automatic flit_t header_of(input int dst_x, input int dst_y, input int count);
        flit_t f;
        f = '0;
        f[`NOC_HDR_DST_Y_LSB +: 2] = 2'(dst_y);
        f[`NOC_HDR_DST_X_LSB +: 2] = 2'(dst_x);
        f[`NOC_HDR_SRC_Y_LSB +: 2] = 2'(ROUTER_Y);
        f[`NOC_HDR_SRC_X_LSB +: 2] = 2'(ROUTER_X);
        f[`NOC_HDR_CNT_LSB +: 8]   = 8'(count);
        return f;
    endfunction

    function automatic flit_t subheader_of(input axi_id_t id, input axi_addr_t addr,
                                           input axi_len_t len, input axi_size_t size,
                                           input axi_burst_t burst);
        flit_t f;
        f = '0;
        f[`NOC_SUB_BURST_LSB +: 2] = burst;
        f[`NOC_SUB_SIZE_LSB +: 3]  = size;
        f[`NOC_SUB_LEN_LSB +: 8]   = len;
        f[`NOC_SUB_ADDR_LSB +: 16] = addr;
        f[`NOC_SUB_ID_LSB +: 4]    = id;
        return f;
    endfunction

    task automatic push_flit(input flit_t d, input logic [1:0] k, input axi_strb_t s,
                             input logic l);
        flit_rec_t r;
        r.data = d;
        r.kind = k;
        r.strb = s;
        r.last = l;
        exp_q.push_back(r);
    endtask

    task automatic expect_read(input axi_id_t id, input axi_addr_t addr, input axi_len_t len,
                               input int dst_x, input int dst_y);
        push_flit(header_of(dst_x, dst_y, 1), FLIT_HEAD, 4'hf, 1'b0);
        push_flit(subheader_of(id, addr, len, 3'd2, 2'd1), FLIT_AR, 4'hf, 1'b1);
    endtask

    task automatic expect_write(input axi_id_t id, input axi_addr_t addr, input axi_len_t len,
                                input int dst_x, input int dst_y, input int base);
        push_flit(header_of(dst_x, dst_y, int'(len) + 2), FLIT_HEAD, 4'hf, 1'b0);
        push_flit(subheader_of(id, addr, len, 3'd2, 2'd1), FLIT_AW, 4'hf, 1'b0);
        for (int b = 0; b <= int'(len); b++) begin
            push_flit({8'h00, wdata_buf[base + b]}, FLIT_W, wstrb_buf[base + b],
                      b == int'(len));
        end
    endtask

    task automatic fill_write_data(input int base, input int n);
        logic [31:0] v;
        for (int i = 0; i < n; i++) begin
            take_bits(32, v);
            wdata_buf[base + i] = v;
            take_bits(4, v);
            wstrb_buf[base + i] = v[3:0];
        end
    endtask

    function automatic logic ready_of(input int ch);
        case (ch)
            CH_AW:   return awready;
            CH_W:    return wready;
            default: return arready;
        endcase
    endfunction

    task automatic wait_accept(input int ch, input string name);
        int cnt;
        cnt = 0;
        @(posedge ACLK);
        while (!ready_of(ch)) begin
            cnt++;
            assert (cnt < WAIT_LIMIT) else report_error({"no handshake seen on ", name});
            @(posedge ACLK);
        end
    endtask

    // called at a falling edge and returns at one, so requests can follow back to back
    task automatic send_write(input axi_id_t id, input axi_addr_t addr, input axi_len_t len,
                              input int base);
        awvalid = 1'b1;
        awid    = id;
        awaddr  = addr;
        awlen   = len;
        awsize  = 3'd2;
        awburst = 2'd1;
        wait_accept(CH_AW, "awready_o");
        @(negedge ACLK);
        awvalid = 1'b0;
        for (int b = 0; b <= int'(len); b++) begin
            wvalid = 1'b1;
            wdata  = wdata_buf[base + b];
            wstrb  = wstrb_buf[base + b];
            wlast  = (b == int'(len));
            wait_accept(CH_W, "wready_o");
            @(negedge ACLK);
        end
        wvalid = 1'b0;
        wlast  = 1'b0;
    endtask

    task automatic send_read(input axi_id_t id, input axi_addr_t addr, input axi_len_t len);
        arvalid = 1'b1;
        arid    = id;
        araddr  = addr;
        arlen   = len;
        arsize  = 3'd2;
        arburst = 2'd1;
        wait_accept(CH_AR, "arready_o");
        @(negedge ACLK);
        arvalid = 1'b0;
    endtask

    task automatic check_flits(input string label);
        int cnt;
        cnt = 0;
        while (got_q.size() < exp_q.size()) begin
            @(posedge ACLK);
            cnt++;
            assert (cnt < WAIT_LIMIT) else report_error({label, " did not deliver all flits"});
        end
        repeat (3) @(posedge ACLK); // catches repeated flits
        assert (got_q.size() == exp_q.size())
            else report_mismatch("flit count", got_q.size(), exp_q.size());
        for (int i = 0; i < exp_q.size(); i++) begin
            assert (got_q[i].data == exp_q[i].data)
                else report_mismatch($sformatf("m_tdata_o[%0d]", i), got_q[i].data,
                                     exp_q[i].data);
            assert (got_q[i].kind == exp_q[i].kind)
                else report_mismatch($sformatf("m_tid_o[%0d]", i), got_q[i].kind,
                                     exp_q[i].kind);
            assert (got_q[i].strb == exp_q[i].strb)
                else report_mismatch($sformatf("m_tstrb_o[%0d]", i), got_q[i].strb,
                                     exp_q[i].strb);
            assert (got_q[i].last == exp_q[i].last)
                else report_mismatch($sformatf("m_tlast_o[%0d]", i), got_q[i].last,
                                     exp_q[i].last);
        end
        got_q.delete();
        exp_q.delete();
    endtask

    task automatic apply_reset();
        ARESETn = 1'b0;
        repeat (8) @(negedge ACLK);
        ARESETn = 1'b1;
    endtask

    task automatic quiet_after_reset();
        repeat (20) begin
            @(posedge ACLK);
            assert (!m_tvalid && !awready && !arready && !wready)
                else report_mismatch("{m_tvalid_o,awready_o,arready_o,wready_o}",
                                     {m_tvalid, awready, arready, wready}, 0);
        end
    endtask

    task automatic read_packet();
        logic [31:0] v;
        @(negedge ACLK);
        take_bits(16, v);
        ar_seen = 0;
        expect_read(4'd6, v[15:0], 8'd3, 1, 1);
        send_read(4'd6, v[15:0], 8'd3);
        check_flits("read packet");
        assert (ar_seen == 1) else report_mismatch("arready_o pulse count", ar_seen, 1);
    endtask

    task automatic write_burst();
        logic [31:0] v;
        @(negedge ACLK);
        take_bits(16, v);
        fill_write_data(0, 4);
        expect_write(4'd1, v[15:0], 8'd3, 0, 0, 0);
        send_write(4'd1, v[15:0], 8'd3, 0);
        check_flits("write burst");
    endtask

    task automatic back_pressure_traffic();
        logic [31:0] v;
        logic [31:0] u;
        bp_en = 1'b1;
        @(negedge ACLK);
        take_bits(16, v);
        take_bits(16, u);
        fill_write_data(0, 6);
        expect_write(4'd9, v[15:0], 8'd5, 0, 2, 0); // id 9 sits at x=0, y=2
        expect_read(4'd12, u[15:0], 8'd7, 3, 2);
        send_write(4'd9, v[15:0], 8'd5, 0);
        send_read(4'd12, u[15:0], 8'd7);
        check_flits("back-pressure traffic");
        bp_en = 1'b0;
    endtask

    task automatic id_wraparound();
        logic [31:0] v;
        @(negedge ACLK);
        take_bits(16, v);
        expect_read(4'd0, v[15:0], 8'd0, 3, 3);
        send_read(4'd0, v[15:0], 8'd0);
        check_flits("id wrap");
    endtask

    task automatic round_robin_order();
        @(negedge ACLK);
        apply_reset();
        fill_write_data(0, 2);
        fill_write_data(4, 1);
        // a second write follows at once, but the waiting read has priority by then
        expect_write(4'd5, 16'h1200, 8'd1, 0, 1, 0);
        expect_read(4'd10, 16'h3400, 8'd2, 1, 2);
        expect_write(4'd15, 16'h5600, 8'd0, 2, 3, 4);
        fork
            begin
                send_write(4'd5, 16'h1200, 8'd1, 0);
                send_write(4'd15, 16'h5600, 8'd0, 4);
            end
            send_read(4'd10, 16'h3400, 8'd2);
        join
        check_flits("round-robin order");
    endtask

    initial begin
        ACLK = 1'b0;
        ARESETn = 1'b0;
        awvalid = 1'b0;
        awid = '0;
        awaddr = '0;
        awlen = '0;
        awsize = '0;
        awburst = '0;
        wvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wlast = 1'b0;
        arvalid = 1'b0;
        arid = '0;
        araddr = '0;
        arlen = '0;
        arsize = '0;
        arburst = '0;
        m_tready = 1'b1;
        bp_en = 1'b0;
        ar_seen = 0;
        data_lfsr = LFSR_SEED;
        ready_lfsr = LFSR_SEED;
        apply_reset();
        quiet_after_reset();
        read_packet();
        write_burst();
        back_pressure_traffic();
        id_wraparound();
        round_robin_order();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== noc_req_bridge.f ====
+incdir+logic
logic/noc_flit_pkg.sv
logic/noc_axi_pkg.sv
logic/burst_if.sv
logic/req_arbiter.sv
logic/packet_fsm.sv
logic/beat_counter.sv
logic/flit_packer.sv
logic/noc_req_bridge.sv
testbench/tb_noc_req_bridge.sv

// ==== Bender.yml ====
package:
  name: noc_req_bridge

sources:
  - include_dirs:
      - logic
    files:
      - logic/noc_flit_pkg.sv
      - logic/noc_axi_pkg.sv
      - logic/burst_if.sv
      - logic/req_arbiter.sv
      - logic/packet_fsm.sv
      - logic/beat_counter.sv
      - logic/flit_packer.sv
      - logic/noc_req_bridge.sv
  - target: test
    include_dirs:
      - logic
    files:
      - testbench/tb_noc_req_bridge.sv
